//--- common/memw_defines.svh
`ifndef MEMW_DEFINES_SVH
`define MEMW_DEFINES_SVH

// data word width in bits
`define MEMW_WORD_W 32

// words per cache line, sets the eviction burst length
`define MEMW_LINE_WORDS 8

// total request queue depth, half of it per source
`define MEMW_QUEUE_DEPTH 8

// byte address width
`define MEMW_ADDR_W 32

`endif

//--- common/memw_pkg.sv
`default_nettype none

`include "memw_defines.svh"

package memw_pkg;

    typedef logic [`MEMW_WORD_W-1:0] word_t;

    // slot index inside one source
    typedef logic [$clog2(`MEMW_QUEUE_DEPTH / 2)-1:0] slot_t;

    // queue key, source bit above the slot
    typedef struct packed {
        logic  unc;  // 1 uncached store, 0 eviction
        slot_t slot;
    } key_t;

    // write request descriptor
    typedef struct packed {
        logic [`MEMW_ADDR_W-1:0]   addr;
        logic [7:0]                len;   // beats minus one
        logic [2:0]                size;
        logic [`MEMW_WORD_W/8-1:0] strb;
    } write_req_t;

endpackage

`default_nettype wire

//--- common/axi_pkg.sv
`default_nettype none

package axi_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_t;

    typedef logic [2:0] size_t;
    typedef logic [1:0] resp_t;

    localparam size_t SIZE_1B = 3'b000;
    localparam size_t SIZE_2B = 3'b001;
    localparam size_t SIZE_4B = 3'b010;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

//--- src/victim_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "memw_defines.svh"

module victim_buffer (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_we,
    input  memw_pkg::slot_t                         i_wr_slot,
    input  memw_pkg::word_t [`MEMW_LINE_WORDS-1:0]  i_line,
    input  memw_pkg::slot_t                         i_rd_slot,
    output memw_pkg::word_t [`MEMW_LINE_WORDS-1:0]  o_line
);

    localparam int SLOTS = `MEMW_QUEUE_DEPTH / 2;

    // one evicted line per slot
    memw_pkg::word_t [`MEMW_LINE_WORDS-1:0] r_lines [SLOTS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int s = 0; s < SLOTS; s++) begin
                r_lines[s] <= '0;
            end
        end else if (i_we) begin
            r_lines[i_wr_slot] <= i_line;  // whole line in one cycle
        end
    end

    // read by key slot when a burst starts
    assign o_line = r_lines[i_rd_slot];

endmodule

`default_nettype wire

//--- mem_write/dual_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "memw_defines.svh"

module dual_fifo #(
    parameter int DATA_W = 32
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_push_a,
    input  logic [DATA_W-1:0] i_data_a,
    input  logic              i_push_b,
    input  logic [DATA_W-1:0] i_data_b,
    input  logic              i_pop,
    output logic [DATA_W-1:0] o_data,
    output logic              o_empty_a,
    output logic              o_empty_b,
    output logic              o_empty
);

    localparam int DEPTH = `MEMW_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH / 2) + 1;

    logic [DATA_W-1:0] r_mem [DEPTH];
    logic              r_src [DEPTH];  // 1 when entry came from port a
    logic [PTR_W-1:0]  r_wptr;
    logic [PTR_W-1:0]  r_rptr;
    logic [CNT_W-1:0]  r_cnt_a;
    logic [CNT_W-1:0]  r_cnt_b;
    logic [PTR_W-1:0]  w_wptr_b;
    logic              w_pop;
    logic              w_pop_a;
    logic              w_pop_b;

    assign w_wptr_b = r_wptr + PTR_W'(i_push_a);  // b lands behind a on a double push
    assign w_pop    = i_pop && !o_empty;
    assign w_pop_a  = w_pop && r_src[r_rptr];
    assign w_pop_b  = w_pop && !r_src[r_rptr];

    always_ff @(posedge i_clk) begin
        if (i_push_a) begin
            r_mem[r_wptr] <= i_data_a;
            r_src[r_wptr] <= 1'b1;
        end
        if (i_push_b) begin
            r_mem[w_wptr_b] <= i_data_b;
            r_src[w_wptr_b] <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wptr  <= '0;
            r_rptr  <= '0;
            r_cnt_a <= '0;
            r_cnt_b <= '0;
        end else begin
            r_wptr  <= w_wptr_b + PTR_W'(i_push_b);
            r_cnt_a <= r_cnt_a + CNT_W'(i_push_a) - CNT_W'(w_pop_a);
            r_cnt_b <= r_cnt_b + CNT_W'(i_push_b) - CNT_W'(w_pop_b);
            if (w_pop) begin
                r_rptr <= r_rptr + 1'b1;
            end
        end
    end

    assign o_data    = r_mem[r_rptr];  // head, combinational
    assign o_empty_a = (r_cnt_a == '0);
    assign o_empty_b = (r_cnt_b == '0);
    assign o_empty   = o_empty_a && o_empty_b;

endmodule

`default_nettype wire

//--- mem_write/mem_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "memw_defines.svh"

module mem_write (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_evict_we,
    input  logic [`MEMW_ADDR_W-1:0]                 i_evict_addr,
    input  logic                                    i_unc_we,
    input  logic [`MEMW_ADDR_W-1:0]                 i_unc_addr,
    input  memw_pkg::word_t                         i_unc_data,
    input  logic [`MEMW_WORD_W/8-1:0]               i_unc_strb,
    input  memw_pkg::word_t [`MEMW_LINE_WORDS-1:0]  i_line,
    input  logic                                    i_axi_awready,
    input  logic                                    i_axi_wready,
    input  logic                                    i_axi_bvalid,
    output memw_pkg::slot_t                         o_evict_lock,
    output memw_pkg::slot_t                         o_line_slot,
    output logic                                    o_evict_full,
    output logic                                    o_unc_full,
    output logic                                    o_empty,
    output logic                                    o_busy,
    output logic                                    o_axi_awvalid,
    output logic [`MEMW_ADDR_W-1:0]                 o_axi_awaddr,
    output logic [7:0]                              o_axi_awlen,
    output axi_pkg::size_t                          o_axi_awsize,
    output axi_pkg::burst_t                         o_axi_awburst,
    output logic                                    o_axi_wvalid,
    output memw_pkg::word_t                         o_axi_wdata,
    output logic [`MEMW_WORD_W/8-1:0]               o_axi_wstrb,
    output logic                                    o_axi_wlast,
    output logic                                    o_axi_bready
);

    localparam int SLOTS  = `MEMW_QUEUE_DEPTH / 2;
    localparam int BEAT_W = $clog2(`MEMW_LINE_WORDS);
    localparam int STRB_W = `MEMW_WORD_W / 8;
    localparam int Q_W    = $bits(memw_pkg::key_t) + $bits(memw_pkg::write_req_t);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    function automatic memw_pkg::slot_t first_free(input logic [SLOTS-1:0] occ);
        memw_pkg::slot_t idx;
        idx = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!occ[i]) begin
                idx = memw_pkg::slot_t'(i);
            end
        end
        return idx;
    endfunction

    state_t                                 r_state;
    logic [SLOTS-1:0]                       r_occ_evict;
    logic [SLOTS-1:0]                       r_occ_unc;
    memw_pkg::word_t                        r_unc_word [SLOTS];
    logic                                   r_push_a;
    logic                                   r_push_b;
    memw_pkg::key_t                         r_key_a;
    memw_pkg::key_t                         r_key_b;
    memw_pkg::write_req_t                   r_req_a;
    memw_pkg::write_req_t                   r_req_b;
    memw_pkg::word_t [`MEMW_LINE_WORDS-1:0] r_data;
    logic [7:0]                             r_beat;
    memw_pkg::slot_t                        w_evict_lock;
    memw_pkg::slot_t                        w_unc_lock;
    logic [Q_W-1:0]                         w_head;
    memw_pkg::key_t                         w_head_key;
    memw_pkg::write_req_t                   w_head_req;
    logic                                   w_q_empty;
    logic                                   w_empty_a;
    logic                                   w_empty_b;
    logic                                   w_aw_hs;
    logic                                   w_b_hs;
    logic                                   w_last;

    assign w_evict_lock = first_free(r_occ_evict);
    assign w_unc_lock   = first_free(r_occ_unc);
    assign {w_head_key, w_head_req} = w_head;

    assign w_aw_hs = (r_state == ST_ADDR) && i_axi_awready;
    assign w_b_hs  = (r_state == ST_RESP) && i_axi_bvalid;
    assign w_last  = (r_beat == w_head_req.len);

    // request capture, pushed into the queue one cycle later
    always_ff @(posedge i_clk) begin
        if (i_unc_we) begin
            r_key_a <= '{unc: 1'b1, slot: w_unc_lock};
            r_req_a <= '{addr: i_unc_addr, len: 8'd0, size: axi_pkg::SIZE_4B, strb: i_unc_strb};
            r_unc_word[w_unc_lock] <= i_unc_data;
        end
        if (i_evict_we) begin
            r_key_b <= '{unc: 1'b0, slot: w_evict_lock};
            r_req_b <= '{addr: i_evict_addr, len: 8'(`MEMW_LINE_WORDS - 1),
                         size: axi_pkg::SIZE_4B, strb: {STRB_W{1'b1}}};
        end
        if (w_aw_hs) begin
            if (w_head_key.unc) begin
                r_data[0] <= r_unc_word[w_head_key.slot];
            end else begin
                r_data <= i_line;  // line from victim slot
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state     <= ST_IDLE;
            r_occ_evict <= '0;
            r_occ_unc   <= '0;
            r_push_a    <= 1'b0;
            r_push_b    <= 1'b0;
            r_beat      <= '0;
        end else begin
            r_push_a <= i_unc_we;
            r_push_b <= i_evict_we;
            if (i_unc_we) begin
                r_occ_unc[w_unc_lock] <= 1'b1;
            end
            if (i_evict_we) begin
                r_occ_evict[w_evict_lock] <= 1'b1;
            end
            if (w_b_hs) begin
                if (w_head_key.unc) begin
                    r_occ_unc[w_head_key.slot] <= 1'b0;
                end else begin
                    r_occ_evict[w_head_key.slot] <= 1'b0;
                end
            end
            case (r_state)
                ST_IDLE: begin
                    if (!w_q_empty) begin
                        r_state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (i_axi_awready) begin
                        r_state <= ST_DATA;
                        r_beat  <= '0;
                    end
                end
                ST_DATA: begin
                    if (i_axi_wready) begin
                        r_beat <= r_beat + 1'b1;
                        if (w_last) begin
                            r_state <= ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    if (i_axi_bvalid) begin
                        r_state <= ST_IDLE;  // slot freed, head popped
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    dual_fifo #(
        .DATA_W (Q_W)
    ) u_queue (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_push_a  (r_push_a),  // uncached goes first on a pair
        .i_data_a  ({r_key_a, r_req_a}),
        .i_push_b  (r_push_b),
        .i_data_b  ({r_key_b, r_req_b}),
        .i_pop     (w_b_hs),
        .o_data    (w_head),
        .o_empty_a (w_empty_a),
        .o_empty_b (w_empty_b),
        .o_empty   (w_q_empty)
    );

    assign o_evict_lock = w_evict_lock;
    assign o_line_slot  = w_head_key.slot;
    assign o_evict_full = &r_occ_evict;
    assign o_unc_full   = &r_occ_unc;
    assign o_empty      = w_empty_a && w_empty_b && !r_push_a && !r_push_b;
    assign o_busy       = (r_state != ST_IDLE);

    assign o_axi_awvalid = (r_state == ST_ADDR);
    assign o_axi_awaddr  = w_head_req.addr;
    assign o_axi_awlen   = w_head_req.len;
    assign o_axi_awsize  = axi_pkg::size_t'(w_head_req.size);
    assign o_axi_awburst = w_head_key.unc ? axi_pkg::BURST_FIXED : axi_pkg::BURST_INCR;
    assign o_axi_wvalid  = (r_state == ST_DATA);
    assign o_axi_wdata   = r_data[r_beat[BEAT_W-1:0]];
    assign o_axi_wstrb   = w_head_req.strb;
    assign o_axi_wlast   = (r_state == ST_DATA) && w_last;
    assign o_axi_bready  = 1'b1;

endmodule

`default_nettype wire

//--- src/memw_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "memw_defines.svh"

module memw_top (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_evict_we,
    input  logic [`MEMW_ADDR_W-1:0]                 i_evict_addr,
    input  memw_pkg::word_t [`MEMW_LINE_WORDS-1:0]  i_evict_line,
    input  logic                                    i_unc_we,
    input  logic [`MEMW_ADDR_W-1:0]                 i_unc_addr,
    input  memw_pkg::word_t                         i_unc_data,
    input  logic [`MEMW_WORD_W/8-1:0]               i_unc_strb,
    input  logic                                    i_axi_awready,
    input  logic                                    i_axi_wready,
    input  logic                                    i_axi_bvalid,
    output logic                                    o_evict_full,
    output logic                                    o_unc_full,
    output logic                                    o_empty,
    output logic                                    o_busy,
    output logic                                    o_axi_awvalid,
    output logic [`MEMW_ADDR_W-1:0]                 o_axi_awaddr,
    output logic [7:0]                              o_axi_awlen,
    output axi_pkg::size_t                          o_axi_awsize,
    output axi_pkg::burst_t                         o_axi_awburst,
    output logic                                    o_axi_wvalid,
    output memw_pkg::word_t                         o_axi_wdata,
    output logic [`MEMW_WORD_W/8-1:0]               o_axi_wstrb,
    output logic                                    o_axi_wlast,
    output logic                                    o_axi_bready
);

    memw_pkg::slot_t                        w_dcache_lock;
    memw_pkg::slot_t                        w_line_slot;
    memw_pkg::word_t [`MEMW_LINE_WORDS-1:0] w_line;

    victim_buffer u_victim (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (i_evict_we),
        .i_wr_slot (w_dcache_lock),  // slot locked by the write unit
        .i_line    (i_evict_line),
        .i_rd_slot (w_line_slot),
        .o_line    (w_line)
    );

    mem_write u_write (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_evict_we    (i_evict_we),
        .i_evict_addr  (i_evict_addr),
        .i_unc_we      (i_unc_we),
        .i_unc_addr    (i_unc_addr),
        .i_unc_data    (i_unc_data),
        .i_unc_strb    (i_unc_strb),
        .i_line        (w_line),
        .i_axi_awready (i_axi_awready),
        .i_axi_wready  (i_axi_wready),
        .i_axi_bvalid  (i_axi_bvalid),
        .o_evict_lock  (w_dcache_lock),
        .o_line_slot   (w_line_slot),
        .o_evict_full  (o_evict_full),
        .o_unc_full    (o_unc_full),
        .o_empty       (o_empty),
        .o_busy        (o_busy),
        .o_axi_awvalid (o_axi_awvalid),
        .o_axi_awaddr  (o_axi_awaddr),
        .o_axi_awlen   (o_axi_awlen),
        .o_axi_awsize  (o_axi_awsize),
        .o_axi_awburst (o_axi_awburst),
        .o_axi_wvalid  (o_axi_wvalid),
        .o_axi_wdata   (o_axi_wdata),
        .o_axi_wstrb   (o_axi_wstrb),
        .o_axi_wlast   (o_axi_wlast),
        .o_axi_bready  (o_axi_bready)
    );

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;  // 100 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/memw_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "memw_defines.svh"

module memw_asserts (
    input logic                    i_clk,
    input logic                    i_rst,
    input logic                    i_evict_we,
    input logic                    i_unc_we,
    input logic                    i_evict_full,
    input logic                    i_unc_full,
    input logic                    i_awvalid,
    input logic                    i_awready,
    input logic [`MEMW_ADDR_W-1:0] i_awaddr,
    input logic [7:0]              i_awlen,
    input logic                    i_wvalid,
    input logic                    i_wready,
    input logic [`MEMW_WORD_W-1:0] i_wdata,
    input logic                    i_wlast
);

    int fail_count = 0;

    logic [7:0] r_len;    // awlen of the open burst
    logic [7:0] r_beats;  // W beats accepted so far

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_len   <= '0;
            r_beats <= '0;
        end else if (i_awvalid && i_awready) begin
            r_len   <= i_awlen;
            r_beats <= '0;
        end else if (i_wvalid && i_wready) begin
            r_beats <= r_beats + 1'b1;
        end
    end

    aw_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr) && $stable(i_awlen))
        else begin
            fail_count++;
            $error("awvalid dropped or address changed before awready");
        end

    w_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wlast))
        else begin
            fail_count++;
            $error("wvalid dropped or wdata changed before wready");
        end

    wlast_on_last_beat: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_wvalid || i_wlast) |-> i_wvalid && (i_wlast == (r_beats == r_len)))
        else begin
            fail_count++;
            $error("wlast high without wvalid or not on the final beat");
        end

    // source side must honor the full flags
    no_evict_when_full: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_evict_we && i_evict_full))
        else begin
            fail_count++;
            $error("eviction strobe while o_evict_full is high");
        end

    no_store_when_full: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_unc_we && i_unc_full))
        else begin
            fail_count++;
            $error("uncached strobe while o_unc_full is high");
        end

endmodule

bind memw_top memw_asserts u_asserts (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_evict_we   (i_evict_we),
    .i_unc_we     (i_unc_we),
    .i_evict_full (o_evict_full),
    .i_unc_full   (o_unc_full),
    .i_awvalid    (o_axi_awvalid),
    .i_awready    (i_axi_awready),
    .i_awaddr     (o_axi_awaddr),
    .i_awlen      (o_axi_awlen),
    .i_wvalid     (o_axi_wvalid),
    .i_wready     (i_axi_wready),
    .i_wdata      (o_axi_wdata),
    .i_wlast      (o_axi_wlast)
);

`default_nettype wire

//--- tests/tb_memw.sv
`timescale 1ns/1ps
`default_nettype none

`include "memw_defines.svh"

module tb_memw;

    localparam int LINE_W     = `MEMW_LINE_WORDS;
    localparam int STRB_W     = `MEMW_WORD_W / 8;
    localparam int MAX_REQ    = 64;
    localparam int WAIT_LIMIT = 4000;
    localparam logic [`MEMW_ADDR_W-1:0] PAIR_EVICT_OFFSET = 32'h0001_0000;

    logic                         clk;
    logic                         rst;
    logic                         evict_we;
    logic [`MEMW_ADDR_W-1:0]      evict_addr;
    memw_pkg::word_t [LINE_W-1:0] evict_line;
    logic                         unc_we;
    logic [`MEMW_ADDR_W-1:0]      unc_addr;
    memw_pkg::word_t              unc_data;
    logic [STRB_W-1:0]            unc_strb;
    logic                         awready;
    logic                         wready;
    logic                         bvalid;
    logic                         evict_full;
    logic                         unc_full;
    logic                         empty;
    logic                         busy;
    logic                         awvalid;
    logic [`MEMW_ADDR_W-1:0]      awaddr;
    logic [7:0]                   awlen;
    axi_pkg::size_t               awsize;
    axi_pkg::burst_t              awburst;
    logic                         wvalid;
    memw_pkg::word_t              wdata;
    logic [STRB_W-1:0]            wstrb;
    logic                         wlast;
    logic                         bready;

    // expected bursts in arrival order
    logic [`MEMW_ADDR_W-1:0] exp_addr [MAX_REQ];
    logic                    exp_unc  [MAX_REQ];
    memw_pkg::word_t         exp_word [MAX_REQ];  // store data or line seed
    logic [STRB_W-1:0]       exp_strb [MAX_REQ];
    int                      exp_head;
    int                      exp_tail;
    int                      cur;
    int                      beat;
    logic                    burst_open;
    int                      mismatches;
    int                      failures;
    logic [31:0]             lfsr;
    logic                    stall;
    logic                    last_hs;
    int                      resp_cnt;
    logic                    ok;

    clk_gen #(.HALF_PERIOD(50), .RESET_CYCLES(8)) u_clk (
        .o_clk (clk),
        .o_rst (rst)
    );

    memw_top dut0 (
        .i_clk (clk), .i_rst (rst),
        .i_evict_we (evict_we), .i_evict_addr (evict_addr), .i_evict_line (evict_line),
        .i_unc_we (unc_we), .i_unc_addr (unc_addr), .i_unc_data (unc_data),
        .i_unc_strb (unc_strb),
        .i_axi_awready (awready), .i_axi_wready (wready), .i_axi_bvalid (bvalid),
        .o_evict_full (evict_full), .o_unc_full (unc_full), .o_empty (empty), .o_busy (busy),
        .o_axi_awvalid (awvalid), .o_axi_awaddr (awaddr), .o_axi_awlen (awlen),
        .o_axi_awsize (awsize), .o_axi_awburst (awburst),
        .o_axi_wvalid (wvalid), .o_axi_wdata (wdata), .o_axi_wstrb (wstrb),
        .o_axi_wlast (wlast), .o_axi_bready (bready)
    );

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_random_bit(output logic b);
        b = lfsr[0];
        lfsr = next_lfsr(lfsr);
    endtask

    task automatic note_failure(input string what);
        failures++;
        $display("FAILURE at %0t: %s", $time, what);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_expected(input logic unc, input logic [31:0] addr,
                                input memw_pkg::word_t word, input logic [STRB_W-1:0] strb);
        assert (exp_tail < MAX_REQ) else note_failure("too many requests in stimulus file");
        if (exp_tail < MAX_REQ) begin
            exp_unc[exp_tail]  = unc;
            exp_addr[exp_tail] = addr;
            exp_word[exp_tail] = word;
            exp_strb[exp_tail] = strb;
            exp_tail++;
        end
    endtask

    // slave model, random ready and delayed write response
    always @(posedge clk) begin
        logic b0;
        logic b1;
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            resp_cnt = 0;
            last_hs  = 1'b0;
        end else begin
            take_random_bit(b0);
            awready <= b0 && !stall;
            take_random_bit(b1);
            wready <= b1 && !stall;
            if (last_hs) begin
                take_random_bit(b0);
                take_random_bit(b1);
                resp_cnt = ({b1, b0} == 2'd3) ? 1 : int'({b1, b0}) + 1;  // 1 to 3 cycles
                last_hs  = 1'b0;
            end
            bvalid <= (resp_cnt == 1);
            if (resp_cnt > 0) begin
                resp_cnt--;
            end
        end
    end

    // burst monitor, sampled mid-cycle
    always @(negedge clk) begin
        int last_beat;
        if (!rst && awvalid && awready) begin
            assert (!burst_open) else note_failure("new AW before the previous burst ended");
            assert (exp_head < exp_tail) else note_failure("AW burst with no pending request");
            if (exp_head < exp_tail) begin
                cur = exp_head;
                exp_head++;
                beat = 0;
                burst_open = 1'b1;
                compare_value("o_axi_awaddr", awaddr, exp_addr[cur]);
                compare_value("o_axi_awlen", awlen, exp_unc[cur] ? 0 : LINE_W - 1);
                compare_value("o_axi_awburst", awburst,
                              exp_unc[cur] ? axi_pkg::BURST_FIXED : axi_pkg::BURST_INCR);
                compare_value("o_axi_awsize", awsize, $clog2(STRB_W));
            end
        end
        if (!rst && wvalid && wready) begin
            assert (burst_open) else note_failure("W beat outside a burst");
            if (burst_open) begin
                last_beat = exp_unc[cur] ? 0 : LINE_W - 1;
                compare_value("o_axi_wdata", wdata,
                              exp_unc[cur] ? exp_word[cur] : exp_word[cur] + beat);
                compare_value("o_axi_wstrb", wstrb,
                              exp_unc[cur] ? exp_strb[cur] : {STRB_W{1'b1}});
                compare_value("o_axi_wlast", wlast, beat == last_beat);
                beat++;
                if (beat > last_beat) begin
                    burst_open = 1'b0;
                    last_hs    = 1'b1;
                end
            end
        end
        if (!rst && bvalid) begin
            compare_value("o_axi_bready", bready, 1);
        end
    end

    task automatic wait_until_clear(input logic need_unc, input logic need_evict,
                                    output logic clear);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (((need_unc && unc_full) || (need_evict && evict_full)) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        clear = !((need_unc && unc_full) || (need_evict && evict_full));
        assert (clear) else note_failure("timeout waiting for a full flag to clear");
    endtask

    task automatic wait_for_empty(output logic drained);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!empty && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        drained = empty;
        assert (drained) else note_failure("timeout waiting for o_empty");
    endtask

    task automatic drive_request(input logic [3:0] kind, input logic [31:0] addr,
                                 input memw_pkg::word_t data, input logic [STRB_W-1:0] strb,
                                 output logic sent);
        memw_pkg::word_t [LINE_W-1:0] line_v;
        logic [31:0]                  eaddr;
        eaddr = (kind == 4'd2) ? addr + PAIR_EVICT_OFFSET : addr;
        for (int i = 0; i < LINE_W; i++) begin
            line_v[i] = data + memw_pkg::word_t'(i);  // seed plus word index
        end
        wait_until_clear(kind != 4'd1, kind != 4'd0, sent);
        if (sent) begin
            @(posedge clk);
            if (kind != 4'd1) begin
                unc_we   <= 1'b1;
                unc_addr <= addr;
                unc_data <= data;
                unc_strb <= strb;
                add_expected(1'b1, addr, data, strb);  // store first in a pair
            end
            if (kind != 4'd0) begin
                evict_we   <= 1'b1;
                evict_addr <= eaddr;
                evict_line <= line_v;
                add_expected(1'b0, eaddr, data, {STRB_W{1'b1}});
            end
            @(posedge clk);
            unc_we   <= 1'b0;
            evict_we <= 1'b0;
        end
    endtask

    task automatic run_stimulus(output logic done);
        string             line;
        int                fd;
        int                n;
        logic [3:0]        kind;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [STRB_W-1:0] strb;
        int                gap;
        done = 1'b1;
        fd = $fopen("tests/memw_stim.txt", "r");
        assert (fd != 0) else note_failure("cannot open tests/memw_stim.txt");
        if (fd == 0) begin
            done = 1'b0;
        end
        while (done && fd != 0 && $fgets(line, fd) != 0) begin
            n = 0;
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", kind, addr, data, strb, gap);
            end
            if (n == 5) begin
                if (kind <= 4'd2) begin
                    drive_request(kind, addr, data, strb, done);
                end else if (kind == 4'd3) begin
                    wait_for_empty(done);
                    stall = 1'b1;  // hold both ready lines low
                end else if (kind == 4'd4) begin
                    @(negedge clk);
                    compare_value("o_unc_full", unc_full, 1);
                    stall = 1'b0;
                end
                repeat (gap) @(posedge clk);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin
        int cycles;
        evict_we   = 1'b0;
        evict_addr = '0;
        evict_line = '0;
        unc_we     = 1'b0;
        unc_addr   = '0;
        unc_data   = '0;
        unc_strb   = '0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        lfsr       = 32'h7191;
        stall      = 1'b0;
        last_hs    = 1'b0;
        resp_cnt   = 0;
        burst_open = 1'b0;
        exp_head   = 0;
        exp_tail   = 0;
        mismatches = 0;
        failures   = 0;
        cycles     = 0;
        @(negedge clk);
        while (rst && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = !rst;
        assert (ok) else note_failure("reset never released");
        if (ok) begin
            compare_value("o_axi_awvalid", awvalid, 0);
            compare_value("o_axi_wvalid", wvalid, 0);
            compare_value("o_evict_full", evict_full, 0);
            compare_value("o_unc_full", unc_full, 0);
            compare_value("o_busy", busy, 0);
            compare_value("o_empty", empty, 1);
            run_stimulus(ok);
        end
        if (ok) begin
            wait_for_empty(ok);
        end
        if (ok) begin
            repeat (2) @(negedge clk);
            assert (exp_head == exp_tail && !burst_open)
                else note_failure("not every expected burst was seen on AXI");
            compare_value("o_busy", busy, 0);
        end
        $display("errors: %0d mismatches, %0d failures, %0d assertion failures",
                 mismatches, failures, dut0.u_asserts.fail_count);
        if (ok && mismatches == 0 && failures == 0 && dut0.u_asserts.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/memw_stim.txt
# columns: kind addr data strb gap, all hex; data is the line seed for evictions
# kind 0 store, 1 eviction, 2 store plus eviction at addr+10000, 3 stall ready, 4 expect unc full
0 00001000 deadbeef f 3
0 00001004 12345678 3 0
1 00002000 a0000000 f 2
1 00002020 b0000000 f 0
2 00003000 cafe0001 c 1
0 00001008 0badf00d 1 0
2 00003100 cafe0002 f 0
1 00002040 c0000000 f 0
1 00002060 d0000000 f 0
1 00002080 e0000000 f 0
1 000020a0 f0000000 f 4
0 0000100c 55aa55aa 6 0
3 00000000 00000000 0 0
0 00004000 11111111 f 0
0 00004004 22222222 f 0
0 00004008 33333333 f 0
0 0000400c 44444444 f 1
4 00000000 00000000 0 2
2 00005000 abcd0003 f 0

//--- sim.f
+incdir+common
common/memw_pkg.sv
common/axi_pkg.sv
src/victim_buffer.sv
mem_write/dual_fifo.sv
mem_write/mem_write.sv
src/memw_top.sv
tests/clk_gen.sv
tests/memw_asserts.sv
tests/tb_memw.sv

//--- Bender.yml
package:
  name: memw

export_include_dirs:
  - common

sources:
  - common/memw_pkg.sv
  - common/axi_pkg.sv
  - src/victim_buffer.sv
  - mem_write/dual_fifo.sv
  - mem_write/mem_write.sv
  - src/memw_top.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/memw_asserts.sv
      - tests/tb_memw.sv
